/* source/miniRvPkg.sv */
`default_nettype none

package miniRvPkg;

   localparam int xlen = 32;

   typedef logic [4:0] regAddrT;

   localparam logic [6:0] opLui   = 7'b0110111;
   localparam logic [6:0] opOpImm = 7'b0010011;
   localparam logic [6:0] opOp    = 7'b0110011;
   localparam logic [6:0] opLoad  = 7'b0000011;
   localparam logic [6:0] opStore = 7'b0100011;
   localparam logic [6:0] opHalt  = 7'h7F;

   typedef struct packed {
      logic [6:0] funct7;
      regAddrT    rs2;
      regAddrT    rs1;
      logic [2:0] funct3;
      regAddrT    rd;
      logic [6:0] opcode;
   } rViewT;

   typedef struct packed {
      logic [11:0] imm12;
      regAddrT     rs1;
      logic [2:0]  funct3;
      regAddrT     rd;
      logic [6:0]  opcode;
   } iViewT;

   typedef struct packed {
      logic [6:0] immHi;
      regAddrT    rs2;
      regAddrT    rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      logic [6:0] opcode;
   } sViewT;

   typedef struct packed {
      logic [19:0] imm20;
      regAddrT     rd;
      logic [6:0]  opcode;
   } uViewT;

   // one fetched word, four ways to look at it
   typedef union packed {
      rViewT rView;
      iViewT iView;
      sViewT sView;
      uViewT uView;
   } instrWordT;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluSlt, aluSltu, aluXor, aluOr, aluAnd,
      aluSll, aluSrl, aluSra, aluPassB
   } aluOpT;

   typedef enum logic [2:0] {
      kindAlu, kindLoad, kindStore, kindHalt, kindInvalid
   } instrKindT;

   typedef struct packed {
      instrKindT        kind;
      aluOpT            aluOp;
      logic             useImm;
      logic [xlen-1:0]  imm;    // final operand value
      regAddrT          rs1;
      regAddrT          rs2;
      regAddrT          rd;
   } decodedT;

endpackage

`default_nettype wire

/* source/fetchControl.sv */
`default_nettype none

module fetchControl #(
   parameter int addrWidth = 16
) (
   input  wire logic                          clk,
   input  wire logic                          rstn,
   input  wire logic                          start,
   input  wire logic                          memVld,
   input  wire logic [miniRvPkg::xlen-1:0]    memRData,
   input  wire miniRvPkg::decodedT            dec,
   input  wire logic [miniRvPkg::xlen-1:0]    aluResult,
   input  wire logic [miniRvPkg::xlen-1:0]    rs2Data,
   output miniRvPkg::instrWordT               instr,
   output logic                               memReq,
   output logic                               memWe,
   output logic [addrWidth-1:0]               memAddr,
   output logic [miniRvPkg::xlen-1:0]         memWData,
   output logic                               wbEn,
   output logic                               wbFromMem,
   output logic                               halted
);

   typedef enum logic [1:0] {stIdle, stFetch, stExec, stMem} stateT;

   stateT                state;
   logic [addrWidth-1:0] pc;
   logic                 fetchIssue;
   logic                 fetchDone;
   logic                 memIssue;

   assign fetchIssue = (state == stFetch) && !memReq;
   assign fetchDone  = (state == stFetch) && memReq && memVld;
   assign memIssue   = (state == stExec) &&
                       (dec.kind == miniRvPkg::kindLoad || dec.kind == miniRvPkg::kindStore);

   // alu results retire in exec, loads when the data arrives
   assign wbEn = ((state == stExec) && (dec.kind == miniRvPkg::kindAlu)) ||
                 ((state == stMem) && memVld && !memWe);
   assign wbFromMem = (state == stMem);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state  <= stIdle;
         pc     <= '0;
         halted <= 1'b1;
         memReq <= 1'b0;
         memWe  <= 1'b0;
      end else begin
         case (state)
            stIdle: begin
               if (start) begin
                  state  <= stFetch;
                  halted <= 1'b0;
               end
            end
            stFetch: begin
               if (fetchIssue) begin
                  memReq <= 1'b1;
                  memWe  <= 1'b0;
               end else if (memVld) begin
                  memReq <= 1'b0;
                  pc     <= pc + 1'b1;
                  state  <= stExec;
               end
            end
            stExec: begin
               if (dec.kind == miniRvPkg::kindAlu) begin
                  state <= stFetch;
               end else if (memIssue) begin
                  state  <= stMem;
                  memReq <= 1'b1;
                  memWe  <= (dec.kind == miniRvPkg::kindStore);
               end else begin
                  state  <= stIdle; // halt or bad encoding
                  halted <= 1'b1;
               end
            end
            default: begin
               if (memVld) begin
                  memReq <= 1'b0;
                  memWe  <= 1'b0;
                  state  <= stFetch;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (fetchIssue) begin
         memAddr <= pc;
      end else if (memIssue) begin
         memAddr <= aluResult[addrWidth-1:0]; // word index
      end
      if (memIssue) begin
         memWData <= rs2Data;
      end
      if (fetchDone) begin
         instr <= memRData;
      end
   end

   // request fields hold until the memory answers
   reqStable: assert property (@(posedge clk) disable iff (!rstn)
      memReq && !memVld |=> $stable(memAddr) && $stable(memWe) && (!memWe || $stable(memWData)));

   reqDrops: assert property (@(posedge clk) disable iff (!rstn)
      memReq && memVld |=> !memReq);

endmodule

`default_nettype wire

/* source/instrDecoder.sv */
`default_nettype none

module instrDecoder (
   input  wire miniRvPkg::instrWordT instr,
   output miniRvPkg::decodedT        dec
);

   logic [miniRvPkg::xlen-1:0] immI;
   logic [miniRvPkg::xlen-1:0] immS;
   logic [miniRvPkg::xlen-1:0] shamt;

   assign immI  = {{20{instr.iView.imm12[11]}}, instr.iView.imm12};
   assign immS  = {{20{instr.sView.immHi[6]}}, instr.sView.immHi, instr.sView.immLo};
   assign shamt = {27'b0, instr.iView.imm12[4:0]};

   always_comb begin
      dec        = '0;
      dec.kind   = miniRvPkg::kindInvalid;
      dec.aluOp  = miniRvPkg::aluAdd;
      case (instr.rView.opcode)
         miniRvPkg::opLui: begin
            dec.kind   = miniRvPkg::kindAlu;
            dec.aluOp  = miniRvPkg::aluPassB;
            dec.useImm = 1'b1;
            dec.imm    = {instr.uView.imm20, 12'b0};
            dec.rd     = instr.uView.rd;
         end
         miniRvPkg::opOpImm: begin
            dec.kind   = miniRvPkg::kindAlu;
            dec.useImm = 1'b1;
            dec.imm    = immI;
            dec.rs1    = instr.iView.rs1;
            dec.rd     = instr.iView.rd;
            case (instr.iView.funct3)
               3'b000: dec.aluOp = miniRvPkg::aluAdd;
               3'b010: dec.aluOp = miniRvPkg::aluSlt;
               3'b011: dec.aluOp = miniRvPkg::aluSltu;
               3'b100: dec.aluOp = miniRvPkg::aluXor;
               3'b110: dec.aluOp = miniRvPkg::aluOr;
               3'b111: dec.aluOp = miniRvPkg::aluAnd;
               3'b001: begin
                  dec.aluOp = miniRvPkg::aluSll;
                  dec.imm   = shamt;
                  if (instr.rView.funct7 != 7'b0000000) dec.kind = miniRvPkg::kindInvalid;
               end
               default: begin
                  dec.imm = shamt; // srli or srai
                  if (instr.rView.funct7 == 7'b0000000) begin
                     dec.aluOp = miniRvPkg::aluSrl;
                  end else if (instr.rView.funct7 == 7'b0100000) begin
                     dec.aluOp = miniRvPkg::aluSra;
                  end else begin
                     dec.kind = miniRvPkg::kindInvalid;
                  end
               end
            endcase
         end
         miniRvPkg::opOp: begin
            dec.kind = miniRvPkg::kindAlu;
            dec.rs1  = instr.rView.rs1;
            dec.rs2  = instr.rView.rs2;
            dec.rd   = instr.rView.rd;
            if (instr.rView.funct7 == 7'b0000000) begin
               case (instr.rView.funct3)
                  3'b000:  dec.aluOp = miniRvPkg::aluAdd;
                  3'b001:  dec.aluOp = miniRvPkg::aluSll;
                  3'b010:  dec.aluOp = miniRvPkg::aluSlt;
                  3'b011:  dec.aluOp = miniRvPkg::aluSltu;
                  3'b100:  dec.aluOp = miniRvPkg::aluXor;
                  3'b110:  dec.aluOp = miniRvPkg::aluOr;
                  3'b111:  dec.aluOp = miniRvPkg::aluAnd;
                  default: dec.kind  = miniRvPkg::kindInvalid; // no srl
               endcase
            end else if (instr.rView.funct7 == 7'b0100000 && instr.rView.funct3 == 3'b000) begin
               dec.aluOp = miniRvPkg::aluSub;
            end else begin
               dec.kind = miniRvPkg::kindInvalid;
            end
         end
         miniRvPkg::opLoad: begin
            if (instr.iView.funct3 == 3'b010) dec.kind = miniRvPkg::kindLoad;
            dec.useImm = 1'b1;
            dec.imm    = immI;
            dec.rs1    = instr.iView.rs1;
            dec.rd     = instr.iView.rd;
         end
         miniRvPkg::opStore: begin
            if (instr.sView.funct3 == 3'b010) dec.kind = miniRvPkg::kindStore;
            dec.useImm = 1'b1;
            dec.imm    = immS;
            dec.rs1    = instr.sView.rs1;
            dec.rs2    = instr.sView.rs2;
         end
         miniRvPkg::opHalt: dec.kind = miniRvPkg::kindHalt;
         default: dec.kind = miniRvPkg::kindInvalid;
      endcase
   end

   // checked whenever a new word lands in the instruction register
   aluOpLegal: assert property (@(instr)
      dec.kind == miniRvPkg::kindAlu |-> !$isunknown(dec.aluOp) && dec.aluOp <= miniRvPkg::aluPassB);

endmodule

`default_nettype wire

/* source/aluExecute.sv */
`default_nettype none

module aluExecute (
   input  wire miniRvPkg::decodedT         dec,
   input  wire logic [miniRvPkg::xlen-1:0] rs1Data,
   input  wire logic [miniRvPkg::xlen-1:0] rs2Data,
   output logic [miniRvPkg::xlen-1:0]      aluResult
);

   logic [miniRvPkg::xlen-1:0] opB;
   logic [4:0]                 shamt;

   assign opB   = dec.useImm ? dec.imm : rs2Data;
   assign shamt = opB[4:0];

   always_comb begin
      case (dec.aluOp)
         miniRvPkg::aluAdd:   aluResult = rs1Data + opB; // also load/store address
         miniRvPkg::aluSub:   aluResult = rs1Data - opB;
         miniRvPkg::aluSlt:   aluResult = {31'b0, $signed(rs1Data) < $signed(opB)};
         miniRvPkg::aluSltu:  aluResult = {31'b0, rs1Data < opB};
         miniRvPkg::aluXor:   aluResult = rs1Data ^ opB;
         miniRvPkg::aluOr:    aluResult = rs1Data | opB;
         miniRvPkg::aluAnd:   aluResult = rs1Data & opB;
         miniRvPkg::aluSll:   aluResult = rs1Data << shamt;
         miniRvPkg::aluSrl:   aluResult = rs1Data >> shamt;
         miniRvPkg::aluSra:   aluResult = $unsigned($signed(rs1Data) >>> shamt);
         default:             aluResult = opB; // lui
      endcase
   end

endmodule

`default_nettype wire

/* source/writeBack.sv */
`default_nettype none

module writeBack (
   input  wire logic                       clk,
   input  wire logic                       rstn,
   input  wire miniRvPkg::decodedT         dec,
   input  wire logic                       wbEn,
   input  wire logic                       wbFromMem,
   input  wire logic [miniRvPkg::xlen-1:0] aluResult,
   input  wire logic [miniRvPkg::xlen-1:0] memRData,
   output logic [miniRvPkg::xlen-1:0]      rs1Data,
   output logic [miniRvPkg::xlen-1:0]      rs2Data
);

   logic [miniRvPkg::xlen-1:0] regs [0:31]; // entry 0 is x0, cleared and never written
   logic [miniRvPkg::xlen-1:0] wData;

   assign wData = wbFromMem ? memRData : aluResult;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wbEn && dec.rd != '0) begin
         regs[dec.rd] <= wData; // x0 writes dropped
      end
   end

   assign rs1Data = regs[dec.rs1];
   assign rs2Data = regs[dec.rs2];

   // a write aimed at x0 leaves it reading zero afterwards
   x0Zero: assert property (@(posedge clk) disable iff (!rstn)
      wbEn && dec.rd == '0 |=> (dec.rs1 != '0 || rs1Data == '0) &&
                               (dec.rs2 != '0 || rs2Data == '0));

endmodule

`default_nettype wire

/* source/miniRvCore.sv */
`default_nettype none

module miniRvCore #(
   parameter int addrWidth = 16
) (
   input  wire logic                       clk,
   input  wire logic                       rstn,
   input  wire logic                       start,
   input  wire logic                       memVld,
   input  wire logic [miniRvPkg::xlen-1:0] memRData,
   output wire logic                       memReq,
   output wire logic                       memWe,
   output wire logic [addrWidth-1:0]       memAddr,
   output wire logic [miniRvPkg::xlen-1:0] memWData,
   output wire logic                       halted
);

   miniRvPkg::instrWordT       instr;
   miniRvPkg::decodedT         dec;
   logic [miniRvPkg::xlen-1:0] rs1Data;
   logic [miniRvPkg::xlen-1:0] rs2Data;
   logic [miniRvPkg::xlen-1:0] aluResult;
   logic                       wbEn;
   logic                       wbFromMem;

   fetchControl #(
      .addrWidth(addrWidth)
   ) fetchCtl (
      .clk       (clk),
      .rstn      (rstn),
      .start     (start),
      .memVld    (memVld),
      .memRData  (memRData),
      .dec       (dec),
      .aluResult (aluResult),
      .rs2Data   (rs2Data),
      .instr     (instr),
      .memReq    (memReq),
      .memWe     (memWe),
      .memAddr   (memAddr),
      .memWData  (memWData),
      .wbEn      (wbEn),
      .wbFromMem (wbFromMem),
      .halted    (halted)
   );

   instrDecoder decoder (
      .instr (instr),
      .dec   (dec)
   );

   aluExecute alu (
      .dec       (dec),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .aluResult (aluResult)
   );

   writeBack regFile (
      .clk       (clk),
      .rstn      (rstn),
      .dec       (dec),
      .wbEn      (wbEn),
      .wbFromMem (wbFromMem),
      .aluResult (aluResult),
      .memRData  (memRData),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data)
   );

endmodule

`default_nettype wire

/* test/memModel.sv */
`default_nettype none

module memModel (
   input  wire logic        clk,
   input  wire logic        rstn,
   input  wire logic        memReq,
   input  wire logic        memWe,
   input  wire logic [15:0] memAddr,
   input  wire logic [31:0] memWData,
   output logic             memVld,
   output logic [31:0]      memRData,
   output logic [15:0]      progLen,
   output logic [7:0]       storeCount,
   output logic [7:0]       expStores,
   output logic             storeError
);

   localparam logic [31:0] valA = 32'hFFFF_FFF9; // x1
   localparam logic [31:0] valB = 32'h8765_4321; // x3
   localparam logic [15:0] storeBase = 16'd128;

   logic [31:0] words [0:65535];
   logic [31:0] expData [0:255];
   logic [1:0]  waitCnt;
   int          seed = 4469;

   function automatic logic [31:0] immOp(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
      return {imm, rs1, f3, rd, miniRvPkg::opOpImm};
   endfunction

   function automatic logic [31:0] regOp(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {f7, rs2, rs1, f3, 5'd10, miniRvPkg::opOp};
   endfunction

   task automatic emit(input logic [31:0] w);
      words[progLen] = w;
      progLen = progLen + 16'd1;
   endtask

   // sw of src into the next result slot
   task automatic storeReg(input logic [4:0] src, input logic [31:0] value);
      logic [11:0] off;
      off = 12'(storeBase) + {4'b0, expStores};
      emit({off[11:5], src, 5'd0, 3'b010, off[4:0], miniRvPkg::opStore});
      expData[expStores] = value;
      expStores = expStores + 8'd1;
   endtask

   task automatic aluStore(input logic [31:0] w, input logic [31:0] value);
      emit(w);
      storeReg(5'd10, value); // results land in x10
   endtask

   initial begin
      for (int i = 0; i < 65536; i++) begin
         words[i[15:0]] = {~i[15:0], i[15:0]};
      end
      words[64] = 32'h1357_9BDF;
      words[65] = 32'hCAFE_F00D;
      progLen   = '0;
      expStores = '0;
      emit(immOp(12'hFF9, 5'd0, 3'b000, 5'd1)); // x1 = -7
      emit({20'h87654, 5'd2, miniRvPkg::opLui});
      emit(immOp(12'h321, 5'd2, 3'b000, 5'd3));
      storeReg(5'd2, {20'h87654, 12'h000});
      aluStore(immOp(12'hFFF, 5'd3, 3'b000, 5'd10), valB - 32'd1);
      aluStore(immOp(12'd5, 5'd1, 3'b010, 5'd10), 32'd1); // -7 < 5 only when signed
      aluStore(immOp(12'd5, 5'd1, 3'b011, 5'd10), 32'd0);
      aluStore(immOp(12'h7FF, 5'd3, 3'b100, 5'd10), valB ^ 32'h0000_07FF);
      aluStore(immOp(12'h0F0, 5'd1, 3'b110, 5'd10), valA | 32'h0000_00F0);
      aluStore(immOp(12'hF00, 5'd3, 3'b111, 5'd10), valB & 32'hFFFF_FF00);
      aluStore(immOp(12'h004, 5'd3, 3'b001, 5'd10), valB << 4);
      aluStore(immOp(12'h008, 5'd3, 3'b101, 5'd10), valB >> 8);
      aluStore(immOp(12'h408, 5'd3, 3'b101, 5'd10), {{8{valB[31]}}, valB[31:8]});
      aluStore(regOp(7'h00, 5'd3, 5'd1, 3'b000), valA + valB);
      aluStore(regOp(7'h20, 5'd3, 5'd1, 3'b000), valA - valB);
      aluStore(regOp(7'h00, 5'd0, 5'd1, 3'b010), 32'd1); // -7 below zero
      aluStore(regOp(7'h00, 5'd1, 5'd0, 3'b011), 32'd1); // zero below x1 unsigned
      aluStore(regOp(7'h00, 5'd3, 5'd1, 3'b100), valA ^ valB);
      aluStore(regOp(7'h00, 5'd3, 5'd1, 3'b110), valA | valB);
      aluStore(regOp(7'h00, 5'd3, 5'd1, 3'b111), valA & valB);
      aluStore(regOp(7'h00, 5'd1, 5'd3, 3'b001), valB << valA[4:0]);
      emit({12'd64, 5'd0, 3'b010, 5'd5, miniRvPkg::opLoad});
      aluStore(immOp(12'd100, 5'd5, 3'b000, 5'd10), words[64] + 32'd100);
      emit({12'd65, 5'd0, 3'b010, 5'd0, miniRvPkg::opLoad}); // load aimed at x0
      storeReg(5'd0, 32'd0);
      emit({25'b0, miniRvPkg::opHalt});
      emit(regOp(7'h01, 5'd3, 5'd1, 3'b000)); // mul encoding, not supported
   end

   always @(posedge clk) begin
      if (!rstn) begin
         memVld     <= 1'b0;
         waitCnt    <= 2'd0;
         storeCount <= '0;
         storeError <= 1'b0;
      end else if (memVld) begin
         memVld <= 1'b0;
      end else if (memReq && waitCnt != 2'd0) begin
         waitCnt <= waitCnt - 2'd1;
      end else if (memReq) begin
         memVld  <= 1'b1;
         waitCnt <= 2'($random(seed)); // next answer after 1 to 4 cycles
         if (memWe) begin
            words[memAddr] = memWData;
            storeCount <= storeCount + 8'd1;
            assert (memAddr == storeBase + {8'b0, storeCount}) else begin
               $display("mismatch at %0t: memAddr expected %h got %h", $time,
                        storeBase + {8'b0, storeCount}, memAddr);
               storeError <= 1'b1;
            end
            assert (memWData == expData[storeCount]) else begin
               $display("mismatch at %0t: memWData expected %h got %h", $time,
                        expData[storeCount], memWData);
               storeError <= 1'b1;
            end
         end else begin
            memRData <= words[memAddr];
         end
      end
   end

endmodule

`default_nettype wire

/* test/miniRvCoreTb.sv */
`default_nettype none

module miniRvCoreTb;

   logic        clk;
   logic        rstn;
   logic        start;
   logic        memReq;
   logic        memWe;
   logic        memVld;
   logic        halted;
   logic [15:0] memAddr;
   logic [31:0] memWData;
   logic [31:0] memRData;
   logic [15:0] progLen;
   logic [7:0]  storeCount;
   logic [7:0]  expStores;
   logic        storeError;

   logic        started;
   logic        reqPrev;
   logic        waiting;  // request seen without an answer yet
   logic [15:0] heldAddr;
   logic        heldWe;
   logic [31:0] heldWData;
   logic [15:0] nextFetch;
   int          fetchCount;

   miniRvCore dut (
      .clk      (clk),
      .rstn     (rstn),
      .start    (start),
      .memVld   (memVld),
      .memRData (memRData),
      .memReq   (memReq),
      .memWe    (memWe),
      .memAddr  (memAddr),
      .memWData (memWData),
      .halted   (halted)
   );

   memModel memory (
      .clk        (clk),
      .rstn       (rstn),
      .memReq     (memReq),
      .memWe      (memWe),
      .memAddr    (memAddr),
      .memWData   (memWData),
      .memVld     (memVld),
      .memRData   (memRData),
      .progLen    (progLen),
      .storeCount (storeCount),
      .expStores  (expStores),
      .storeError (storeError)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic failRun(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic showMismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] got);
      failRun($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, expected, got));
   endtask

   task automatic waitHalted(input logic level);
      int cycles;
      cycles = 0;
      while (halted != level) begin
         @(posedge clk);
         cycles = cycles + 1;
         if (cycles > 3000) failRun("timed out waiting for halted to change");
      end
   endtask

   task automatic pulseStart;
      @(posedge clk);
      start   <= 1'b1;
      started = 1'b1;
      @(posedge clk);
      start <= 1'b0;
   endtask

   always @(posedge clk) begin
      if (!rstn) begin
         nextFetch  <= '0;
         fetchCount <= 0;
      end else begin
         assert (started || halted) else failRun("core left halt before any start pulse");
         assert (!(halted && memReq)) else failRun("memory request raised while halted");
         assert (!storeError) else failRun("memory model rejected a store");
         if (waiting) begin
            assert (memAddr == heldAddr) else showMismatch("memAddr", 32'(heldAddr), 32'(memAddr));
            assert (memWe == heldWe) else showMismatch("memWe", 32'(heldWe), 32'(memWe));
            assert (!heldWe || memWData == heldWData)
               else showMismatch("memWData", heldWData, memWData);
         end
         if (memReq && !reqPrev && memAddr < 16'd64) begin // new fetch, data lives above
            assert (memAddr == nextFetch)
               else showMismatch("fetch memAddr", 32'(nextFetch), 32'(memAddr));
            nextFetch  <= memAddr + 16'd1;
            fetchCount <= fetchCount + 1;
         end
      end
      reqPrev   <= rstn && memReq;
      waiting   <= rstn && memReq && !memVld;
      heldAddr  <= memAddr;
      heldWe    <= memWe;
      heldWData <= memWData;
   end

   initial begin
      rstn    <= 1'b0;
      start   <= 1'b0;
      started = 1'b0;
      repeat (5) @(posedge clk);
      rstn <= 1'b1;
      repeat (4) @(posedge clk); // idle, nothing may move
      pulseStart();
      waitHalted(1'b0);
      waitHalted(1'b1);
      assert (fetchCount == int'(progLen) - 1)
         else showMismatch("fetch count", 32'(progLen) - 32'd1, 32'(fetchCount));
      assert (storeCount == expStores)
         else showMismatch("store count", 32'(expStores), 32'(storeCount));
      pulseStart(); // resumes on the bad word
      waitHalted(1'b0);
      waitHalted(1'b1);
      repeat (10) @(posedge clk);
      assert (fetchCount == int'(progLen))
         else showMismatch("fetch count", 32'(progLen), 32'(fetchCount));
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

/* miniRvCore.f */
source/miniRvPkg.sv
source/fetchControl.sv
source/instrDecoder.sv
source/aluExecute.sv
source/writeBack.sv
source/miniRvCore.sv
test/memModel.sv
test/miniRvCoreTb.sv

/* Makefile */
TOP = miniRvCoreTb

all: run

build:
	verilator --binary --timing --assert -f miniRvCore.f --top-module $(TOP) -o simv

run: build
	./obj_dir/simv | tee sim.log
	grep -q "all tests passed" sim.log

lint:
	verilator --lint-only --timing --assert -Wall -f miniRvCore.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
